/* design/link_pkg.sv */
/*
 * framing constants and vector types shared by the serial link receive path
 * lane frames, handshake heads and the redundant sequence field
 * imported by the lane receivers, the data FSM, the assembler and the top
 */
`default_nettype none

package link_pkg;

	// sync word that opens every lane frame
	localparam int SYNC_BITS = 8;
	localparam logic [SYNC_BITS-1:0] SYNC_WORD = 8'h7e;

	// data lane frame after the sync word
	// useful bits come first and the trailing check bits are dropped
	localparam int LANE_DATA_BITS = 22;
	localparam int CHECK_BITS = 8;
	localparam int LANE_FRAME_BITS = LANE_DATA_BITS + CHECK_BITS;

	// handshake lane frame length
	localparam int HEAD_BITS = 8;

	// four parallel data wires
	localparam int DATA_LANES = 4;

	// seq number is sent four times over and decided by vote
	localparam int SEQ_BITS = 4;

	typedef logic [SYNC_BITS-1:0] sync_t;
	typedef logic [LANE_DATA_BITS-1:0] lane_data_t;
	typedef logic [LANE_FRAME_BITS-1:0] lane_frame_t;
	typedef logic [SEQ_BITS-1:0] seq_field_t;
	typedef logic [3:0] rx_count_t;

	// pid of the handshake head arrives first on the wire
	typedef struct packed {
		logic pid;
		logic pid_n;
		logic [HEAD_BITS-3:0] spare;
	} hnd_head_t;

endpackage

`default_nettype wire

/* design/board_pkg.sv */
/*
 * board contents carried by one data packet
 * tile encoding, reduced board size and the 88-bit packet layout
 * lane 0 carries the top quarter of the packet
 */
`default_nettype none

package board_pkg;

	localparam int TILE_BITS = 4;
	localparam int BOARD_ROWS = 4;
	localparam int BOARD_COLS = 4;
	localparam int NEXT_PIECES = 3;

	// board outputs reset to blank so it must stay 0
	typedef enum logic [TILE_BITS-1:0] {
		BLANK = 4'd0,
		I_PIECE, O_PIECE, T_PIECE, S_PIECE, Z_PIECE, J_PIECE, L_PIECE
	} tile_t;

	typedef logic [3:0] garbage_t;
	typedef tile_t [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_t;
	typedef tile_t [NEXT_PIECES-1:0] queue_t;

	// 4 + 4 + 4 + 12 + 64 = 88 bits fill four lane payloads
	typedef struct packed {
		link_pkg::seq_field_t seq;
		garbage_t garbage;
		tile_t hold;
		queue_t queue;
		board_t playfield;
	} board_pkt_t;

endpackage

`default_nettype wire

/* design/lane_receiver.sv */
/*
 * receiver for one serial lane sampled once per clk
 * hunts for the sync word and then shifts in PAYLOAD_BITS bits MSB first
 * done and the frame stay put until arm drops, which sends it back to hunting
 */
`timescale 1ns/1ps
`default_nettype none

module lane_receiver
	import link_pkg::*;
#(
	parameter int PAYLOAD_BITS = LANE_FRAME_BITS
) (
	input  logic clk,
	input  logic rst_l,
	input  logic arm,
	input  logic serial_in,
	output logic [PAYLOAD_BITS-1:0] frame,
	output logic done
);

	localparam int CNT_W = $clog2(PAYLOAD_BITS);

	typedef enum logic [1:0] {
		HUNT,
		SHIFT,
		HOLD
	} lane_state_t;

	lane_state_t state;
	sync_t window;
	sync_t next_window;
	logic [CNT_W-1:0] bit_cnt;

	// window as it will look after this sample
	assign next_window = {window[SYNC_BITS-2:0], serial_in};

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			state <= HUNT;
			window <= '0;
			bit_cnt <= '0;
		end else if (!arm) begin
			// forget any partial sync and start over
			state <= HUNT;
			window <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				HUNT: begin
					window <= next_window;
					if (next_window == SYNC_WORD) begin
						state <= SHIFT;
						bit_cnt <= '0;
					end
				end
				SHIFT: begin
					bit_cnt <= bit_cnt + 1'b1;
					// last payload bit lands this edge
					if (bit_cnt == CNT_W'(PAYLOAD_BITS - 1))
						state <= HOLD;
				end
				HOLD: begin
					// wait for the disarm
					state <= HOLD;
				end
				default: state <= HUNT;
			endcase
		end
	end

	// payload shift register moves only while shifting
	always_ff @(posedge clk) begin
		if (arm && state == SHIFT)
			frame <= {frame[PAYLOAD_BITS-2:0], serial_in};
	end

	// high the cycle after the last bit
	assign done = (state == HOLD);

endmodule

`default_nettype wire

/* design/data_rx_fsm.sv */
/*
 * control for the four data lanes
 * keeps them armed while a game runs and drops arm for one cycle
 * once every lane holds a frame, so the next frame set can be hunted
 */
`timescale 1ns/1ps
`default_nettype none

module data_rx_fsm
	import link_pkg::*;
(
	input  logic clk,
	input  logic rst_l,
	input  logic game_active,
	input  logic [DATA_LANES-1:0] lane_done,
	output logic lane_arm
);

	typedef enum logic [1:0] {
		IDLE,
		LISTEN,
		CLEAR
	} rx_state_t;

	rx_state_t state;
	logic frame_set_done;

	// all lanes finished their frame
	assign frame_set_done = &lane_done;

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (game_active) state <= LISTEN;
				LISTEN: begin
					if (!game_active)
						state <= IDLE;
					else if (frame_set_done)
						state <= CLEAR;
				end
				// single cycle with arm low
				CLEAR: state <= game_active ? LISTEN : IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign lane_arm = (state == LISTEN);

endmodule

`default_nettype wire

/* design/packet_assembler.sv */
/*
 * rebuilds the board packet from the four lane frames
 * votes the redundant sequence bits and accepts only the expected sequence
 * on accept loads the opponent outputs and pulses update and ack for one cycle
 */
`timescale 1ns/1ps
`default_nettype none

module packet_assembler
	import link_pkg::*;
	import board_pkg::*;
(
	input  logic clk,
	input  logic rst_l,
	input  lane_frame_t lane_frames [DATA_LANES],
	input  logic [DATA_LANES-1:0] lane_done,
	output logic send_ack,
	output logic ack_seq,
	output logic update_opponent_data,
	output garbage_t opponent_garbage,
	output tile_t opponent_hold,
	output queue_t opponent_queue,
	output board_t opponent_playfield,
	output rx_count_t packets_received
);

	lane_data_t lane_data [DATA_LANES];
	board_pkt_t pkt;
	logic frame_set_done;
	logic done_q1;
	logic done_q2;
	logic done_rise;
	logic [2:0] seq_ones;
	logic seq_voted;
	logic exp_seq;
	logic accept;

	// strip the trailing check bits
	always_comb begin
		for (int i = 0; i < DATA_LANES; i++)
			lane_data[i] = lane_frames[i][LANE_FRAME_BITS-1 -: LANE_DATA_BITS];
	end

	// lane 0 is the top quarter
	assign pkt = {lane_data[0], lane_data[1], lane_data[2], lane_data[3]};

	assign frame_set_done = &lane_done;

	// two stages so the pulse lands 2 cycles after the last bit
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			done_q1 <= 1'b0;
			done_q2 <= 1'b0;
		end else begin
			done_q1 <= frame_set_done;
			done_q2 <= done_q1;
		end
	end

	assign done_rise = done_q1 & ~done_q2;

	// a 2-2 tie in the majority of four counts as 1
	assign seq_ones = 3'(pkt.seq[0]) + 3'(pkt.seq[1]) + 3'(pkt.seq[2]) + 3'(pkt.seq[3]);
	assign seq_voted = (seq_ones >= 3'd2);

	assign accept = done_rise && (seq_voted == exp_seq);

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			exp_seq <= 1'b0;
			packets_received <= '0;
			send_ack <= 1'b0;
			update_opponent_data <= 1'b0;
			opponent_garbage <= '0;
			opponent_hold <= BLANK;
			opponent_queue <= '{default: BLANK};
			opponent_playfield <= '{default: BLANK};
		end else begin
			// pulses clear themselves unless a new packet is accepted
			send_ack <= accept;
			update_opponent_data <= accept;
			if (accept) begin
				exp_seq <= ~exp_seq;
				packets_received <= packets_received + 1'b1;
				opponent_garbage <= pkt.garbage;
				opponent_hold <= pkt.hold;
				opponent_queue <= pkt.queue;
				opponent_playfield <= pkt.playfield;
			end
		end
	end

	// sender echoes the seq it expects next
	assign ack_seq = exp_seq;

endmodule

`default_nettype wire

/* design/opponent_receiver.sv */
/*
 * receive side of the board link with four data lanes and a handshake lane
 * top level for the opponent board path and the ack detector
 * outputs hold the last accepted opponent board
 */
`timescale 1ns/1ps
`default_nettype none

module opponent_receiver
	import link_pkg::*;
	import board_pkg::*;
(
	input  logic clk,
	input  logic rst_l,
	input  logic game_active,
	input  logic serial_in_h,
	input  logic [DATA_LANES-1:0] serial_in,
	output logic send_ack,
	output logic ack_seq,
	output logic update_opponent_data,
	output garbage_t opponent_garbage,
	output tile_t opponent_hold,
	output queue_t opponent_queue,
	output board_t opponent_playfield,
	output rx_count_t packets_received,
	output logic ack_received
);

	logic lane_arm;
	logic [DATA_LANES-1:0] lane_done;
	lane_frame_t lane_frames [DATA_LANES];

	logic hnd_arm;
	logic hnd_done;
	logic hnd_done_q1;
	logic hnd_done_q2;
	hnd_head_t hnd_head;

	data_rx_fsm i_data_fsm (
		.clk(clk),
		.rst_l(rst_l),
		.game_active(game_active),
		.lane_done(lane_done),
		.lane_arm(lane_arm)
	);

	// all data wire receivers share one arm
	for (genvar i = 0; i < DATA_LANES; i++) begin : g_data_lane
		lane_receiver #(.PAYLOAD_BITS(LANE_FRAME_BITS)) i_lane_rx (
			.clk(clk),
			.rst_l(rst_l),
			.arm(lane_arm),
			.serial_in(serial_in[i]),
			.frame(lane_frames[i]),
			.done(lane_done[i])
		);
	end

	lane_receiver #(.PAYLOAD_BITS(HEAD_BITS)) i_hnd_rx (
		.clk(clk),
		.rst_l(rst_l),
		.arm(hnd_arm),
		.serial_in(serial_in_h),
		.frame(hnd_head),
		.done(hnd_done)
	);

	packet_assembler i_assembler (
		.clk(clk),
		.rst_l(rst_l),
		.lane_frames(lane_frames),
		.lane_done(lane_done),
		.send_ack(send_ack),
		.ack_seq(ack_seq),
		.update_opponent_data(update_opponent_data),
		.opponent_garbage(opponent_garbage),
		.opponent_hold(opponent_hold),
		.opponent_queue(opponent_queue),
		.opponent_playfield(opponent_playfield),
		.packets_received(packets_received)
	);

	// handshake lane drops arm only in the first done cycle
	// head stays in the frame register until the next sync
	assign hnd_arm = game_active & ~(hnd_done & ~hnd_done_q1);

	// two-stage done edge puts the ack 2 cycles after the last bit
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			hnd_done_q1 <= 1'b0;
			hnd_done_q2 <= 1'b0;
			ack_received <= 1'b0;
		end else begin
			hnd_done_q1 <= hnd_done;
			hnd_done_q2 <= hnd_done_q1;
			// ack head is pid 1 and pid_n 0
			ack_received <= hnd_done_q1 & ~hnd_done_q2 & hnd_head.pid & ~hnd_head.pid_n;
		end
	end

endmodule

`default_nettype wire

/* tests/lane_driver.svh */
/*
 * lane stimulus tasks, included inside the testbench module
 * frames go out MSB first with one bit per clk driven just after the rising edge
 * uses clk, serial_in, serial_in_h, seed and DRIVE_DELAY of the includer
 */
`ifndef LANE_DRIVER_SVH
`define LANE_DRIVER_SVH

// each of the four parallel data lanes carries its own quarter of the packet
task automatic send_board_packet(input board_pkt_t pkt);
	logic [DATA_LANES*LANE_DATA_BITS-1:0] pkt_bits;
	logic [SYNC_BITS+LANE_FRAME_BITS-1:0] lane_word [DATA_LANES];
	pkt_bits = pkt;
	for (int i = 0; i < DATA_LANES; i++) begin
		// lane 0 gets the top quarter and random filler stands in for check bits
		lane_word[i] = {SYNC_WORD,
			pkt_bits[(DATA_LANES-1-i)*LANE_DATA_BITS +: LANE_DATA_BITS],
			CHECK_BITS'($random(seed))};
	end
	for (int b = SYNC_BITS+LANE_FRAME_BITS-1; b >= 0; b--) begin
		@(posedge clk);
		#(DRIVE_DELAY);
		for (int i = 0; i < DATA_LANES; i++)
			serial_in[i] = lane_word[i][b];
	end
endtask

// handshake lane sends sync and then the 8-bit head with pid first
task automatic send_head(input hnd_head_t head);
	logic [SYNC_BITS+HEAD_BITS-1:0] word;
	word = {SYNC_WORD, head};
	for (int b = SYNC_BITS+HEAD_BITS-1; b >= 0; b--) begin
		@(posedge clk);
		#(DRIVE_DELAY);
		serial_in_h = word[b];
	end
endtask

`endif

/* tests/tb_opponent_receiver.sv */
/*
 * testbench for the opponent receive path
 * directed and random frames on the lanes, checked against a board model
 * model keeps the expected sequence, the last accepted board and the counts
 */
`timescale 1ns/1ps
`default_nettype none

module tb_opponent_receiver
	import link_pkg::*;
	import board_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int GAP_BITS = 5;
	localparam int RANDOM_FRAMES = 40;
	localparam int DIRECTED_FRAMES = 12;
	localparam int FRAME_CYCLES = SYNC_BITS + LANE_FRAME_BITS + GAP_BITS + 4;
	localparam int TIMEOUT_NS =
		(10 + (RANDOM_FRAMES + DIRECTED_FRAMES) * FRAME_CYCLES + 200) * CLK_PERIOD;

	logic clk;
	logic rst_l;
	logic game_active;
	logic serial_in_h;
	logic [DATA_LANES-1:0] serial_in;
	logic send_ack;
	logic ack_seq;
	logic update_opponent_data;
	logic ack_received;
	garbage_t opponent_garbage;
	tile_t opponent_hold;
	queue_t opponent_queue;
	board_t opponent_playfield;
	rx_count_t packets_received;

	// reference model
	logic model_seq;
	garbage_t model_garbage;
	tile_t model_hold;
	queue_t model_queue;
	board_t model_playfield;
	int model_accepted;
	int model_acks;

	int update_pulses;
	int ack_pulses;
	int ack_rx_pulses;
	int checks;
	int errors;
	integer seed;

	opponent_receiver i_dut (
		.clk(clk),
		.rst_l(rst_l),
		.game_active(game_active),
		.serial_in_h(serial_in_h),
		.serial_in(serial_in),
		.send_ack(send_ack),
		.ack_seq(ack_seq),
		.update_opponent_data(update_opponent_data),
		.opponent_garbage(opponent_garbage),
		.opponent_hold(opponent_hold),
		.opponent_queue(opponent_queue),
		.opponent_playfield(opponent_playfield),
		.packets_received(packets_received),
		.ack_received(ack_received)
	);

	`include "lane_driver.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// count every pulse on the quiet edge
	always @(negedge clk) begin
		if (update_opponent_data) update_pulses++;
		if (send_ack) ack_pulses++;
		if (ack_received) ack_rx_pulses++;
	end

	task automatic expect_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		expect_value("opponent_garbage", opponent_garbage, model_garbage);
		expect_value("opponent_hold", opponent_hold, model_hold);
		expect_value("opponent_queue", opponent_queue, model_queue);
		expect_value("opponent_playfield", opponent_playfield, model_playfield);
		expect_value("ack_seq", ack_seq, model_seq);
		expect_value("packets_received", packets_received, rx_count_t'(model_accepted));
	endtask

	// 2 or more set bits vote for 1
	function automatic logic vote_seq(input seq_field_t field);
		int ones;
		ones = 0;
		for (int i = 0; i < $bits(field); i++)
			ones += field[i];
		return ones >= 2;
	endfunction

	function automatic tile_t random_tile();
		return tile_t'({1'b0, 3'($random(seed))});
	endfunction

	function automatic board_pkt_t random_packet();
		board_pkt_t p;
		p.seq = seq_field_t'($random(seed));
		p.garbage = garbage_t'($random(seed));
		p.hold = random_tile();
		for (int n = 0; n < NEXT_PIECES; n++)
			p.queue[n] = random_tile();
		for (int r = 0; r < BOARD_ROWS; r++)
			for (int c = 0; c < BOARD_COLS; c++)
				p.playfield[r][c] = random_tile();
		return p;
	endfunction

	// pulses of the idle gap after a frame come only in its third cycle
	task automatic watch_frame_end(input logic exp_update, input logic exp_ack_rx);
		for (int c = 0; c < GAP_BITS; c++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			serial_in = '0;
			serial_in_h = 1'b0;
			expect_value("update_opponent_data", update_opponent_data, exp_update && c == 2);
			expect_value("send_ack", send_ack, exp_update && c == 2);
			expect_value("ack_received", ack_received, exp_ack_rx && c == 2);
			if (c >= 2)
				check_outputs();
		end
	endtask

	task automatic apply_packet(input board_pkt_t pkt);
		logic accept;
		accept = game_active && (vote_seq(pkt.seq) == model_seq);
		if (accept) begin
			model_seq = ~model_seq;
			model_accepted++;
			model_garbage = pkt.garbage;
			model_hold = pkt.hold;
			model_queue = pkt.queue;
			model_playfield = pkt.playfield;
		end
		send_board_packet(pkt);
		watch_frame_end(accept, 1'b0);
	endtask

	task automatic apply_seq_packet(input seq_field_t field);
		board_pkt_t pkt;
		pkt = random_packet();
		pkt.seq = field;
		apply_packet(pkt);
	endtask

	task automatic apply_head(input hnd_head_t head);
		logic exp_ack;
		exp_ack = game_active && head.pid && !head.pid_n;
		if (exp_ack)
			model_acks++;
		send_head(head);
		watch_frame_end(1'b0, exp_ack);
	endtask

	task automatic set_game(input logic active);
		@(posedge clk);
		#(DRIVE_DELAY);
		game_active = active;
		repeat (3) @(posedge clk);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: frames still running after %0d ns", TIMEOUT_NS);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		seed = 37530;
		rst_l = 1'b0;
		game_active = 1'b0;
		serial_in_h = 1'b0;
		serial_in = '0;
		model_seq = 1'b0;
		model_garbage = '0;
		model_hold = BLANK;
		model_queue = '{default: BLANK};
		model_playfield = '{default: BLANK};
		model_accepted = 0;
		model_acks = 0;
		update_pulses = 0;
		ack_pulses = 0;
		ack_rx_pulses = 0;
		checks = 0;
		errors = 0;
		repeat (10) @(posedge clk);
		#(DRIVE_DELAY);
		rst_l = 1'b1;
		@(posedge clk);
		#(DRIVE_DELAY);
		expect_value("update_opponent_data", update_opponent_data, 1'b0);
		expect_value("send_ack", send_ack, 1'b0);
		expect_value("ack_received", ack_received, 1'b0);
		check_outputs();

		// sequence votes where ties count as 1
		set_game(1'b1);
		apply_seq_packet(4'b0000);
		apply_seq_packet(4'b1100);
		apply_seq_packet(4'b0110);
		apply_seq_packet(4'b0001);
		apply_seq_packet(4'b0011);
		apply_seq_packet(4'b1011);

		// only pid 1 with pid_n 0 is an ack
		apply_head(hnd_head_t'({1'b1, 1'b0, 6'h2a}));
		apply_head(hnd_head_t'({1'b1, 1'b1, 6'h15}));
		apply_head(hnd_head_t'({1'b0, 1'b0, 6'h3f}));
		apply_head(hnd_head_t'({1'b0, 1'b1, 6'h00}));

		// nothing is heard without a game
		set_game(1'b0);
		apply_seq_packet({4{model_seq}});
		apply_head(hnd_head_t'({1'b1, 1'b0, 6'h01}));
		set_game(1'b1);

		for (int n = 0; n < RANDOM_FRAMES; n++) begin
			if (2'($random(seed)) == 2'd0)
				apply_head(hnd_head_t'(HEAD_BITS'($random(seed))));
			else
				apply_packet(random_packet());
		end

		expect_value("update pulse count", update_pulses, model_accepted);
		expect_value("send_ack pulse count", ack_pulses, model_accepted);
		expect_value("ack_received pulse count", ack_rx_pulses, model_acks);
		$display("checks: %0d, errors: %0d, accepted: %0d, acks: %0d",
			checks, errors, model_accepted, model_acks);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
design/link_pkg.sv
design/board_pkg.sv
design/lane_receiver.sv
design/data_rx_fsm.sv
design/packet_assembler.sv
design/opponent_receiver.sv
tests/tb_opponent_receiver.sv

/* Makefile */
# Verilator build and run of the opponent receiver testbench
TOP := tb_opponent_receiver
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f vlog.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
